/* sim.f */
design/rtg_pkg.sv
design/rtg_blank_timer.sv
design/rtg_pixel_timer.sv
design/rtg_fetch_fsm.sv
design/rtg_pixel_fifo.sv
design/rtg_video_mixer.sv
design/rtg_display_top.sv
testbench/rtg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the RTG display testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module rtg_tb -o rtg_sim \
	&& ./obj_dir/rtg_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

/* testbench/rtg_tb.sv */
`timescale 1ns/1ns

module rtg_tb import rtg_pkg::*; ();

	localparam int HB_LEN  = 40;  // Hblank clocks per line
	localparam int HS_LEN  = 8;   // Hsync high at start of hblank
	localparam int ACT_LEN = 48;  // Active clocks per line
	localparam int VB_LEN  = 8;   // Vblank clocks per frame

	logic              CLK_114, rst_n;
	rtg_cfg_t          cfg, cfg_next;
	video_t            chip_video, vga;
	logic              hblank, vblank, osd_window, osd_pixel;
	logic              ram_req, ram_fill;
	logic [ADDR_W-1:0] ram_addr;
	logic [WORD_W-1:0] ram_data;

	logic               m_hsync_d, m_rtg_vblank;  // Reference model state
	logic [VBEND_W-1:0] m_line;
	logic [PIXW_W-1:0]  m_pix_cnt;
	logic [WORD_W-1:0]  m_queue [$];              // Words the FIFO should hold
	video_t             m_vga_q;
	logic [ADDR_W-1:0]  exp_addr;                 // Next burst address
	int                 m_fills;
	logic               mem_busy;                 // Memory model state
	logic [ADDR_W-1:0]  mem_addr;
	int                 mem_delay, mem_left, mem_idx, bursts_done;
	int                 errors, tests_run, tests_failed, err_mark;
	logic               rst_next, timed_out;

	rtg_display_top u_dut (.*);

	initial begin
		CLK_114 = 1'b0;
		forever #20 CLK_114 = ~CLK_114;  // 40 ns period
	end

	task automatic compare_video(input string name, input video_t exp, input video_t got);
		if (got !== exp) begin
			$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic compare_rgb(input string name, input rgb_t exp, input rgb_t got);
		if (got !== exp) begin
			$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic compare_addr(input string name, input logic [ADDR_W-1:0] exp,
			input logic [ADDR_W-1:0] got);
		if (got !== exp) begin
			$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	// Top three bits of each 5-bit colour fill the low end
	function automatic rgb_t expand_555(input logic [WORD_W-1:0] w);
		rgb_t c;
		c.r = {w[14:10], w[14:12]};
		c.g = {w[9:5], w[9:7]};
		c.b = {w[4:0], w[4:2]};
		return c;
	endfunction

	function automatic video_t overlay(input video_t v, input logic win, input logic dot);
		video_t     o;
		logic [5:0] osd;
		o   = v;
		osd = dot ? OSD_ON_RGB : OSD_OFF_RGB;
		if (win) begin
			o.rgb.r = {osd[5:4], v.rgb.r[7:2]};  // OSD on top of a dimmed picture
			o.rgb.g = {osd[3:2], v.rgb.g[7:2]};
			o.rgb.b = {osd[1:0], v.rgb.b[7:2]};
		end
		return o;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model stepped on each rising edge
	////////////////////////////////////////////////////////////

	task automatic model_step();
		logic              m_blank, m_pop, m_flush, hs_rise;
		logic [WORD_W-1:0] head;
		if (!rst_n) begin
			m_hsync_d    = 1'b0;
			m_rtg_vblank = 1'b1;
			m_line       = '0;
			m_pix_cnt    = '0;
			m_queue.delete();
			m_vga_q      = '0;
			exp_addr     = '0;
			m_fills      = 0;
		end else begin
			m_blank = m_rtg_vblank | hblank;
			m_pop   = cfg.ena & ~m_blank & (m_pix_cnt == cfg.pixel_width);
			m_flush = m_rtg_vblank | ~cfg.ena;
			hs_rise = chip_video.hsync & ~m_hsync_d;
			head    = '0;
			if (cfg.ena && !m_blank && m_queue.size() == 0) begin
				$display("model pixel queue ran dry at %0t ns", $time);
				errors++;
			end else if (cfg.ena && !m_blank) begin
				head = m_queue[0];
			end
			m_vga_q = chip_video;                  // Chipset unless RTG active
			if (cfg.ena && !m_blank) begin
				m_vga_q.rgb = expand_555(head);
			end
			if (vblank) begin
				m_rtg_vblank = 1'b1;
				m_line       = '0;
			end else if (m_line == cfg.vbend) begin
				m_rtg_vblank = 1'b0;               // RTG picture starts
			end else if (hs_rise) begin
				m_line = m_line + 1'b1;
			end
			m_hsync_d = chip_video.hsync;
			m_pix_cnt = (m_blank || m_pop) ? '0 : m_pix_cnt + 1'b1;
			if (m_flush) begin
				m_queue.delete();
				exp_addr = {cfg.base, 4'b0000};    // Frame base in bytes
				m_fills  = 0;
			end else begin
				if (m_pop && m_queue.size() != 0) begin
					void'(m_queue.pop_front());
				end
				if (ram_fill) begin
					m_queue.push_back(ram_data);
					m_fills++;
				end
				if (m_fills == BURST_LEN) begin
					exp_addr = exp_addr + ADDR_W'(BURST_LEN * 2);
					m_fills  = 0;
				end
			end
		end
	endtask

	// Answers ram_req after a delay with BURST_LEN fills and random gaps
	task automatic memory_step();
		ram_fill = 1'b0;
		if (!ram_req) begin
			mem_busy = 1'b0;                       // Idle or aborted
		end else if (!mem_busy) begin
			mem_busy  = 1'b1;
			mem_addr  = ram_addr;
			compare_addr("ram_addr", exp_addr, ram_addr);
			mem_delay = 1 + int'($urandom % 6);
			mem_left  = BURST_LEN;
			mem_idx   = 0;
		end else if (mem_left == 0) begin
			$display("ram_req still high the cycle after the last fill at %0t ns", $time);
			errors++;
		end else if (mem_delay != 0) begin
			mem_delay--;
		end else begin
			ram_fill  = 1'b1;
			ram_data  = 16'((mem_addr >> 1) + ADDR_W'(mem_idx)) ^ 16'h5a3c;
			mem_idx++;
			mem_left--;
			mem_delay = int'($urandom % 2);        // Gap before next word
			if (mem_left == 0) begin
				bursts_done++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic run_cycle(input logic vb, input logic hb, input logic hs, input logic osd_on);
		video_t exp;
		@(posedge CLK_114);
		model_step();
		#2;
		rst_n            = rst_next;
		cfg              = cfg_next;
		memory_step();
		vblank           = vb;
		hblank           = hb;
		chip_video.rgb   = 24'($urandom);
		chip_video.csync = 1'($urandom);
		chip_video.hsync = hs;
		chip_video.vsync = vb;
		osd_window       = osd_on & 1'($urandom);
		osd_pixel        = 1'($urandom);
		#18;                                       // Check mid-cycle once outputs settle
		exp = overlay(m_vga_q, osd_window, osd_pixel);
		compare_video("vga", exp, vga);
	endtask

	task automatic run_line(input logic osd_on);
		for (int i = 0; i < HB_LEN + ACT_LEN; i++) begin
			run_cycle(1'b0, i < HB_LEN, i < HS_LEN, osd_on);
		end
	endtask

	task automatic run_vblank();
		repeat (VB_LEN) run_cycle(1'b1, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic wait_bursts(input int n, input int limit);
		int start;
		int waited;
		start  = bursts_done;
		waited = 0;
		while (bursts_done - start < n && waited < limit) begin
			run_cycle(1'b0, 1'b1, 1'b0, 1'b0);
			waited++;
		end
		if (bursts_done - start < n) begin
			$display("timed out after %0d cycles waiting for %0d memory bursts", limit, n);
			timed_out = 1'b1;
		end
	endtask

	task automatic end_test(input int num, input string name);
		tests_run++;
		if (errors == err_mark && !timed_out) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", num, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	initial begin
		void'($urandom(32'h8a88));
		rst_n      = 1'b0;
		rst_next   = 1'b0;
		cfg        = '0;
		cfg_next   = '0;
		chip_video = '0;
		{hblank, vblank, osd_window, osd_pixel, ram_fill} = '0;
		ram_data   = '0;
		{mem_busy, timed_out} = '0;
		{bursts_done, errors, tests_run, tests_failed, err_mark} = '0;
		for (int i = 0; i < 2; i++) begin
			rst_next = (i == 1);                   // Released after 2 edges
			run_cycle(1'b0, 1'b0, 1'b0, 1'b0);
			compare_rgb("vga.rgb", '0, vga.rgb);
			if (ram_req !== 1'b0) begin
				$display("ram_req was high during or just after reset at %0t ns", $time);
				errors++;
			end
		end
		end_test(1, "reset state");
		repeat (50) run_cycle(1'($urandom), 1'($urandom), 1'($urandom), 1'b0);
		end_test(2, "rtg off passes chipset video");
		cfg_next.ena         = 1'b1;
		cfg_next.base        = 21'($urandom);
		cfg_next.pixel_width = 4'(3 + $urandom % 3);
		cfg_next.vbend       = '0;             // Picture right after vblank
		run_vblank();
		wait_bursts(3, 100);
		end_test(3, "burst addresses");
		repeat (3) run_line(1'b0);
		end_test(4, "active rtg pixels");
		cfg_next.base        = 21'($urandom);
		cfg_next.pixel_width = 4'(3 + $urandom % 3);
		cfg_next.vbend       = 7'(1 + $urandom % 3);
		run_vblank();
		repeat (int'(cfg_next.vbend) + 1) run_line(1'b0);
		end_test(5, "blanking keeps chipset colour");
		repeat (2) run_line(1'b1);
		end_test(6, "osd overlay");
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0 && !timed_out) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* design/rtg_display_top.sv */
`timescale 1ns/1ns

module rtg_display_top import rtg_pkg::*; (
	input  logic              CLK_114,
	input  logic              rst_n,
	input  rtg_cfg_t          cfg,
	input  video_t            chip_video,
	input  logic              hblank,
	input  logic              vblank,
	input  logic              osd_window,
	input  logic              osd_pixel,
	output logic              ram_req,
	output logic [ADDR_W-1:0] ram_addr,
	input  logic              ram_fill,
	input  logic [WORD_W-1:0] ram_data,
	output video_t            vga
);

	logic              rtg_vblank;
	logic              blank;
	logic              pop;        // Pixel slot ends
	logic              flush;
	logic              room;
	logic [WORD_W-1:0] pix;        // FIFO head

	rtg_blank_timer u_blank (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.vblank     (vblank),
		.hblank     (hblank),
		.hsync      (chip_video.hsync),  // Lines counted on chipset hsync
		.vbend      (cfg.vbend),
		.rtg_vblank (rtg_vblank),
		.blank      (blank)
	);

	rtg_pixel_timer u_pixel (
		.CLK_114     (CLK_114),
		.rst_n       (rst_n),
		.ena         (cfg.ena),
		.blank       (blank),
		.pixel_width (cfg.pixel_width),
		.pop         (pop)
	);

	rtg_fetch_fsm u_fetch (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.rtg_vblank (rtg_vblank),
		.room       (room),
		.ram_fill   (ram_fill),
		.ram_req    (ram_req),
		.ram_addr   (ram_addr),
		.flush      (flush)
	);

	rtg_pixel_fifo u_fifo (
		.CLK_114 (CLK_114),
		.rst_n   (rst_n),
		.flush   (flush),
		.push    (ram_fill),   // Every fill is one word
		.pop     (pop),
		.din     (ram_data),
		.q       (pix),
		.room    (room),
		.empty   ()
	);

	rtg_video_mixer u_mixer (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.ena        (cfg.ena),
		.blank      (blank),
		.pix        (pix),
		.chip_video (chip_video),
		.osd_window (osd_window),
		.osd_pixel  (osd_pixel),
		.vga        (vga)
	);

endmodule

/* design/rtg_video_mixer.sv */
`timescale 1ns/1ns

module rtg_video_mixer import rtg_pkg::*; (
	input  logic              CLK_114,
	input  logic              rst_n,
	input  logic              ena,         // RTG screen on
	input  logic              blank,       // Combined RTG blank
	input  logic [WORD_W-1:0] pix,         // Current 5-5-5 pixel
	input  video_t            chip_video,  // Chipset colour and syncs
	input  logic              osd_window,  // Inside OSD rectangle
	input  logic              osd_pixel,   // OSD dot lit
	output video_t            vga
);

	rgb_t       rtg_rgb;    // Expanded high-colour pixel
	video_t     vga_q;      // Registered video
	logic [5:0] osd_rgb;    // 2 bits per gun

	////////////////////////////////////////////////////////////
	// High-colour expansion
	////////////////////////////////////////////////////////////

	// Top bits repeated into the low end so white stays full scale
	assign rtg_rgb.r = {pix[14:10], pix[14:12]};
	assign rtg_rgb.g = {pix[9:5],   pix[9:7]};
	assign rtg_rgb.b = {pix[4:0],   pix[4:2]};

	////////////////////////////////////////////////////////////
	// Source select and output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			vga_q <= '0;
		end else begin
			vga_q.rgb   <= (ena && !blank) ? rtg_rgb : chip_video.rgb;
			vga_q.csync <= chip_video.csync;  // Syncs keep the same delay
			vga_q.hsync <= chip_video.hsync;
			vga_q.vsync <= chip_video.vsync;
		end
	end

	////////////////////////////////////////////////////////////
	// OSD overlay
	////////////////////////////////////////////////////////////

	assign osd_rgb = osd_pixel ? OSD_ON_RGB : OSD_OFF_RGB;

	// Picture shows through dimmed under the OSD
	assign vga.rgb.r = osd_window ? {osd_rgb[5:4], vga_q.rgb.r[7:2]} : vga_q.rgb.r;
	assign vga.rgb.g = osd_window ? {osd_rgb[3:2], vga_q.rgb.g[7:2]} : vga_q.rgb.g;
	assign vga.rgb.b = osd_window ? {osd_rgb[1:0], vga_q.rgb.b[7:2]} : vga_q.rgb.b;
	assign vga.csync = vga_q.csync;
	assign vga.hsync = vga_q.hsync;
	assign vga.vsync = vga_q.vsync;

endmodule

/* design/rtg_pixel_fifo.sv */
`timescale 1ns/1ns

module rtg_pixel_fifo import rtg_pkg::*; (
	input  logic              CLK_114,
	input  logic              rst_n,
	input  logic              flush,  // Drop all words
	input  logic              push,   // Fill strobe from memory
	input  logic              pop,    // Pixel consumed
	input  logic [WORD_W-1:0] din,
	output logic [WORD_W-1:0] q,      // Oldest word, show-ahead
	output logic              room,   // Space for a whole burst
	output logic              empty
);

	logic [WORD_W-1:0]  mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_CW-1:0] count;    // Words held
	logic               full;
	logic               do_push;
	logic               do_pop;

	assign full    = (count == FIFO_CW'(FIFO_DEPTH));
	assign empty   = (count == '0);
	assign room    = (count <= FIFO_CW'(FIFO_DEPTH - BURST_LEN));
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;
	assign q       = mem[rd_ptr];    // No read latency

	always_ff @(posedge CLK_114) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + FIFO_AW'(do_push);   // Pointers wrap
			rd_ptr <= rd_ptr + FIFO_AW'(do_pop);
			count  <= count + FIFO_CW'(do_push) - FIFO_CW'(do_pop);
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	a_no_overflow : assert property (
		@(posedge CLK_114) disable iff (!rst_n)
		push |-> !full
	) else $error("pixel FIFO push when full");

	a_no_underflow : assert property (
		@(posedge CLK_114) disable iff (!rst_n)
		pop |-> !empty
	) else $error("pixel FIFO pop when empty");

endmodule

/* design/rtg_fetch_fsm.sv */
`timescale 1ns/1ns

module rtg_fetch_fsm import rtg_pkg::*; (
	input  logic              CLK_114,
	input  logic              rst_n,
	input  rtg_cfg_t          cfg,
	input  logic              rtg_vblank,  // RTG vertical blank
	input  logic              room,        // FIFO can take a whole burst
	input  logic              ram_fill,    // One word from memory
	output logic              ram_req,     // Burst request level
	output logic [ADDR_W-1:0] ram_addr,    // Burst start address
	output logic              flush        // Empty the pixel FIFO
);

	fetch_state_t       state;
	logic [BURST_W-1:0] fill_cnt;   // Words received this burst
	logic [ADDR_W-1:0]  fetch_addr; // Next burst address
	logic               last_fill;

	assign flush     = rtg_vblank | ~cfg.ena;  // Restart frame from the top
	assign last_fill = ram_fill && (fill_cnt == BURST_W'(BURST_LEN - 1));
	assign ram_req   = (state != IDLE);        // Held through the burst
	assign ram_addr  = fetch_addr;

	////////////////////////////////////////////////////////////
	// Burst FSM and address counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			fill_cnt   <= '0;
			fetch_addr <= '0;
		end else if (flush) begin
			state      <= IDLE;                   // Abort any burst
			fill_cnt   <= '0;
			fetch_addr <= {cfg.base, 4'b0000};    // Frame base, byte units
		end else begin
			unique case (state)
				IDLE: begin
					if (room) begin
						state <= REQ;
					end
				end
				REQ, FILL: begin
					if (last_fill) begin
						state      <= IDLE;       // Req drops next cycle
						fill_cnt   <= '0;
						fetch_addr <= fetch_addr + ADDR_W'(BURST_BYTES);
					end else if (ram_fill) begin
						state    <= FILL;
						fill_cnt <= fill_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Memory latches the address only once, keep it still
	a_addr_stable : assert property (
		@(posedge CLK_114) disable iff (!rst_n)
		$past(ram_req) && ram_req |-> $stable(ram_addr)
	) else $error("ram_addr moved during request");

	// Memory must not send words nobody asked for
	a_no_stray_fill : assert property (
		@(posedge CLK_114) disable iff (!rst_n || flush)
		state == IDLE |-> !ram_fill
	) else $error("ram_fill with no request");

endmodule

/* design/rtg_pixel_timer.sv */
`timescale 1ns/1ns

module rtg_pixel_timer import rtg_pkg::*; (
	input  logic              CLK_114,
	input  logic              rst_n,
	input  logic              ena,          // RTG screen on
	input  logic              blank,        // Combined RTG blank
	input  logic [PIXW_W-1:0] pixel_width,  // Clocks per pixel minus one
	output logic              pop           // Next pixel from the FIFO
);

	logic [PIXW_W-1:0] pix_cnt;  // Clocks into the current pixel

	// Last clock of a pixel slot
	assign pop = ena & ~blank & (pix_cnt == pixel_width);

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			pix_cnt <= '0;
		end else if (blank || pop) begin
			pix_cnt <= '0;                  // New slot
		end else begin
			pix_cnt <= pix_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// No word may leave the FIFO outside the active area
	a_no_pop_in_blank : assert property (
		@(posedge CLK_114) disable iff (!rst_n)
		blank |-> !pop
	) else $error("pixel pop during blank");

endmodule

/* design/rtg_blank_timer.sv */
`timescale 1ns/1ns

module rtg_blank_timer import rtg_pkg::*; (
	input  logic               CLK_114,
	input  logic               rst_n,
	input  logic               vblank,      // Chipset vertical blank
	input  logic               hblank,      // Chipset horizontal blank
	input  logic               hsync,       // Chipset hsync level
	input  logic [VBEND_W-1:0] vbend,       // Lines to hold blank after vblank
	output logic               rtg_vblank,  // RTG vertical blank
	output logic               blank        // Combined RTG blank
);

	logic               hsync_d;   // Last hsync, for edge detect
	logic               hs_rise;
	logic [VBEND_W-1:0] line_cnt;  // Lines since chipset vblank ended

	assign hs_rise = hsync & ~hsync_d;  // One line per rising edge

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			hsync_d <= 1'b0;
		end else begin
			hsync_d <= hsync;
		end
	end

	////////////////////////////////////////////////////////////
	// Line counter
	////////////////////////////////////////////////////////////

	// The RTG screen may start later than the chipset one, so the
	// blank is held for vbend extra lines after vblank drops.
	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			rtg_vblank <= 1'b1;                     // Blank until first frame
			line_cnt   <= '0;
		end else if (vblank) begin
			rtg_vblank <= 1'b1;                     // Restart each frame
			line_cnt   <= '0;
		end else if (line_cnt == vbend) begin
			rtg_vblank <= 1'b0;                     // Active area starts
		end else if (hs_rise) begin
			line_cnt   <= line_cnt + 1'b1;
		end
	end

	assign blank = rtg_vblank | hblank;  // Either blank stops display

endmodule

/* design/rtg_pkg.sv */
package rtg_pkg;

	////////////////////////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////////////////////////

	localparam int ADDR_W      = 25;                  // Byte address into memory
	localparam int WORD_W      = 16;                  // Memory word, one 5-5-5 pixel
	localparam int BURST_LEN   = 4;                   // Words per fetch burst
	localparam int BURST_W     = $clog2(BURST_LEN);   // Fill counter width
	localparam int BURST_BYTES = BURST_LEN * 2;       // Address step per burst
	localparam int FIFO_DEPTH  = 16;                  // Pixel FIFO words
	localparam int FIFO_AW     = $clog2(FIFO_DEPTH);  // FIFO pointer width
	localparam int FIFO_CW     = FIFO_AW + 1;         // Occupancy, 0 to FIFO_DEPTH
	localparam int PIXW_W      = 4;                   // Clocks per pixel minus one
	localparam int VBEND_W     = 7;                   // Extra vblank lines
	localparam int BASE_W      = ADDR_W - 4;          // Base in 16-byte units

	// OSD colours, two bits per gun, packed as {r, g, b}
	localparam logic [5:0] OSD_ON_RGB  = {2'b11, 2'b11, 2'b11};  // Lit, white
	localparam logic [5:0] OSD_OFF_RGB = {2'b00, 2'b00, 2'b10};  // Unlit, dark blue

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// Colour plus sync levels, chipset in and VGA out
	typedef struct packed {
		rgb_t rgb;
		logic csync;
		logic hsync;
		logic vsync;
	} video_t;

	// RTG screen setup as the CPU programs it
	typedef struct packed {
		logic               ena;          // RTG screen on
		logic [BASE_W-1:0]  base;         // Frame start, 16-byte units
		logic [PIXW_W-1:0]  pixel_width;  // Clocks per pixel minus one
		logic [VBEND_W-1:0] vbend;        // Lines after chipset vblank
	} rtg_cfg_t;

	// Burst fetch states
	typedef enum logic [1:0] {
		IDLE,  // No request out
		REQ,   // Request up, waiting for first word
		FILL   // Words arriving
	} fetch_state_t;

endpackage
